/* ptr_pkg.sv */
////////////////////////////////////////////////////////////
// encodings shared by the TRN decoder, the ring registers and
// the descriptor fetcher; register window sits at BAR offset 0
////////////////////////////////////////////////////////////

package ptr_pkg;

    ////////////////////////////////////////////////////////////
    // TLP fmt/type field, header dword 0 bits 30:24
    ////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        MRD32 = 7'b00_00000,    // 3-DW memory read
        MRD64 = 7'b01_00000,    // 4-DW memory read
        MWR32 = 7'b10_00000,    // 3-DW memory write
        MWR64 = 7'b11_00000     // 4-DW memory write
    } tlp_fmt_t;

    // byte offset bit 3 picks the register inside a ring's slot
    typedef enum logic {
        REG_BASE   = 1'b0,      // ring base address
        REG_SW_PTR = 1'b1       // software producer pointer
    } reg_kind_t;

    // descriptor fetch sequencing
    typedef enum logic [1:0] {
        IDLE,                   // waiting for an offered request
        BUS,                    // wishbone read in progress
        HOLD                    // descriptor waiting for ready
    } fetch_state_t;

    ////////////////////////////////////////////////////////////
    // fixed sizes
    ////////////////////////////////////////////////////////////
    localparam int PAYLOAD_DW      = 2;     // one 64-bit register value
    localparam int DESC_BYTES      = 8;     // descriptor stride in host memory
    localparam int REG_STRIDE_LOG2 = 4;     // 16 bytes per ring
    localparam int BAR_APER_LOG2   = 12;    // 4 KB BAR aperture decoded

endpackage

/* tlp_wr_decoder.sv */
////////////////////////////////////////////////////////////
// catches 64-bit register writes on the TRN receive stream
// no back-pressure; NUM_RINGS >= 2; rrem and discontinue ignored
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tlp_wr_decoder #(
    parameter int BAR_HIT   = 2,
    parameter int NUM_RINGS = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [63:0]                  trn_rd,
    input  logic                         trn_rsof_n,
    input  logic                         trn_reof_n,
    input  logic                         trn_rsrc_rdy_n,
    input  logic [6:0]                   trn_rbar_hit_n,
    output logic                         wr_valid,
    output logic [$clog2(NUM_RINGS)-1:0] wr_ring,
    output ptr_pkg::reg_kind_t           wr_kind,
    output logic [63:0]                  wr_data
);
    import ptr_pkg::*;

    localparam int RB = $clog2(NUM_RINGS);

    typedef enum logic [2:0] {
        ST_HDR,                 // waiting for start of packet
        ST_ADR32,               // address dword plus payload dw0
        ST_ADR64,               // two address dwords
        ST_DAT32,               // payload dw1 only
        ST_DAT64,               // both payload dwords
        ST_SKIP                 // drop until end of packet
    } dec_state_t;

    dec_state_t  state_q;
    tlp_fmt_t    fmt;           // fmt/type of the current beat
    logic        beat;          // source has data
    logic        hdr_ok;        // first beat passes length and bar checks
    logic [31:0] adr_lo;        // low address dword for this beat
    logic        win_ok;        // offset inside register window
    logic [31:0] lo_dw_q;       // 3-DW payload dw0, already swapped

    // PCIe wire order to host order, per dword
    function automatic logic [31:0] dw_swap(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    ////////////////////////////////////////////////////////////
    // header checks
    ////////////////////////////////////////////////////////////
    assign beat   = !trn_rsrc_rdy_n;
    assign fmt    = tlp_fmt_t'(trn_rd[62:56]);
    assign hdr_ok = !trn_rsof_n && !trn_rbar_hit_n[BAR_HIT] &&
                    (trn_rd[41:32] == 10'(PAYLOAD_DW));     // length field

    // 3-DW puts the address in the upper dword, 4-DW low address in the lower
    assign adr_lo = (state_q == ST_ADR32) ? trn_rd[63:32] : trn_rd[31:0];
    assign win_ok = !adr_lo[2] &&                          // qword aligned
                    (adr_lo[BAR_APER_LOG2-1:REG_STRIDE_LOG2+RB] == '0);

    ////////////////////////////////////////////////////////////
    // packet FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= ST_HDR;
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= 1'b0;                               // single-cycle pulse
            if (beat) begin
                case (state_q)
                    ST_HDR: begin
                        if (hdr_ok && fmt == MWR32) begin
                            state_q <= ST_ADR32;
                        end else if (hdr_ok && fmt == MWR64) begin
                            state_q <= ST_ADR64;
                        end else if (!trn_rsof_n && trn_reof_n) begin
                            state_q <= ST_SKIP;             // unsupported, drop rest
                        end
                    end
                    ST_ADR32, ST_ADR64: begin
                        if (win_ok && trn_reof_n) begin
                            state_q <= (state_q == ST_ADR32) ? ST_DAT32 : ST_DAT64;
                        end else begin
                            state_q <= trn_reof_n ? ST_SKIP : ST_HDR;
                        end
                    end
                    ST_DAT32, ST_DAT64: begin
                        if (!trn_reof_n) begin
                            wr_valid <= 1'b1;               // complete 2-DW payload
                        end
                        state_q <= trn_reof_n ? ST_SKIP : ST_HDR;
                    end
                    ST_SKIP: begin
                        if (!trn_reof_n) begin
                            state_q <= ST_HDR;
                        end
                    end
                    default: state_q <= ST_HDR;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // write target and payload capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (beat) begin
            case (state_q)
                ST_ADR32: begin
                    wr_ring <= adr_lo[REG_STRIDE_LOG2 +: RB];
                    wr_kind <= reg_kind_t'(adr_lo[3]);
                    lo_dw_q <= dw_swap(trn_rd[31:0]);       // payload straddles beats
                end
                ST_ADR64: begin
                    wr_ring <= adr_lo[REG_STRIDE_LOG2 +: RB];
                    wr_kind <= reg_kind_t'(adr_lo[3]);
                end
                ST_DAT32: wr_data <= {dw_swap(trn_rd[63:32]), lo_dw_q};
                ST_DAT64: wr_data <= {dw_swap(trn_rd[31:0]), dw_swap(trn_rd[63:32])};
                default: ;
            endcase
        end
    end

endmodule

/* ring_ptr_regs.sv */
////////////////////////////////////////////////////////////
// per-ring base and pointers, round-robin pick of a pending ring
// offer held until req_take; rewriting an offered ring is not checked
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ring_ptr_regs #(
    parameter int NUM_RINGS = 4,
    parameter int RING_LOG2 = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wr_valid,
    input  logic [$clog2(NUM_RINGS)-1:0] wr_ring,
    input  ptr_pkg::reg_kind_t           wr_kind,
    input  logic [63:0]                  wr_data,
    input  logic                         req_take,
    output logic                         req_valid,
    output logic [$clog2(NUM_RINGS)-1:0] req_ring,
    output logic [63:0]                  req_adr
);
    import ptr_pkg::*;

    localparam int RB = $clog2(NUM_RINGS);

    logic [63:0]          base_q   [NUM_RINGS];    // ring base, host address
    logic [RING_LOG2-1:0] sw_ptr_q [NUM_RINGS];    // producer, written by host
    logic [RING_LOG2-1:0] hw_ptr_q [NUM_RINGS];    // consumer, ours
    logic [RING_LOG2-1:0] occ      [NUM_RINGS];    // slots still to fetch
    logic [NUM_RINGS-1:0] base_ok_q;               // base written since reset
    logic [NUM_RINGS-1:0] pending;
    logic [RB-1:0]        last_q;                  // last ring served
    logic [RB-1:0]        idx;
    logic [RB-1:0]        pick;
    logic                 pick_any;

    ////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int r = 0; r < NUM_RINGS; r++) begin
            occ[r]     = sw_ptr_q[r] - hw_ptr_q[r];    // wraps mod ring size
            pending[r] = base_ok_q[r] && (occ[r] != '0);
        end
    end

    // round robin, search starts one past the last served ring
    always_comb begin
        pick_any = 1'b0;
        pick     = last_q;
        idx      = last_q;
        for (int i = 1; i <= NUM_RINGS; i++) begin
            idx = last_q + RB'(i);
            if (!pick_any && pending[idx]) begin
                pick_any = 1'b1;
                pick     = idx;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // register file
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_RINGS; r++) begin
                sw_ptr_q[r] <= '0;
                hw_ptr_q[r] <= '0;
            end
            base_ok_q <= '0;
        end else begin
            if (wr_valid && wr_kind == REG_SW_PTR) begin
                sw_ptr_q[wr_ring] <= wr_data[RING_LOG2-1:0];   // upper bits dropped
            end
            if (wr_valid && wr_kind == REG_BASE) begin
                base_ok_q[wr_ring] <= 1'b1;
            end
            if (req_take) begin
                hw_ptr_q[req_ring] <= hw_ptr_q[req_ring] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid && wr_kind == REG_BASE) begin
            base_q[wr_ring] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // registered offer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
            last_q    <= RB'(NUM_RINGS - 1);            // ring 0 goes first
        end else if (req_take) begin
            req_valid <= 1'b0;                          // gap while pointer moves
            last_q    <= req_ring;
        end else if (!req_valid && pick_any) begin
            req_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!req_valid && pick_any) begin
            req_ring <= pick;
            req_adr  <= base_q[pick] + (64'(hw_ptr_q[pick]) * DESC_BYTES);
        end
    end

endmodule

/* wb_desc_fetch.sv */
////////////////////////////////////////////////////////////
// wishbone classic read master, one transfer at a time
// descriptor held until desc_ready; no error or retry handling
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module wb_desc_fetch #(
    parameter int NUM_RINGS = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    // request from ring registers
    input  logic                         req_valid,
    input  logic [$clog2(NUM_RINGS)-1:0] req_ring,
    input  logic [63:0]                  req_adr,
    output logic                         req_take,
    // wishbone master
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output logic [63:0]                  wb_adr,
    input  logic [63:0]                  wb_dat_r,
    input  logic                         wb_ack,
    // descriptor out
    output logic                         desc_valid,
    output logic [63:0]                  desc_data,
    output logic [$clog2(NUM_RINGS)-1:0] desc_ring,
    input  logic                         desc_ready
);
    import ptr_pkg::*;

    fetch_state_t state_q;

    ////////////////////////////////////////////////////////////
    // outputs decoded from state
    ////////////////////////////////////////////////////////////
    assign req_take   = (state_q == IDLE) && req_valid;    // only when nothing held
    assign wb_cyc     = (state_q == BUS);
    assign wb_stb     = wb_cyc;                            // classic, no pipelining
    assign wb_we      = 1'b0;                              // reads only
    assign desc_valid = (state_q == HOLD);

    ////////////////////////////////////////////////////////////
    // fetch FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_valid) begin
                        state_q <= BUS;                    // cyc rises next cycle
                    end
                end
                BUS: begin
                    if (wb_ack) begin
                        state_q <= HOLD;
                    end
                end
                HOLD: begin
                    if (desc_ready) begin
                        state_q <= IDLE;                   // handshake done
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // address and data capture
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (req_take) begin
            wb_adr    <= req_adr;                          // stable through BUS
            desc_ring <= req_ring;
        end
        if (wb_cyc && wb_ack) begin
            desc_data <= wb_dat_r;                         // held through HOLD
        end
    end

endmodule

/* ptr_fetch_top.sv */
////////////////////////////////////////////////////////////
// TRN register writes in, descriptors out over wishbone reads
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ptr_fetch_top #(
    parameter int BAR_HIT   = 2,
    parameter int NUM_RINGS = 4,
    parameter int RING_LOG2 = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    // TRN receive
    input  logic [63:0]                  trn_rd,
    input  logic                         trn_rsof_n,
    input  logic                         trn_reof_n,
    input  logic                         trn_rsrc_rdy_n,
    input  logic [6:0]                   trn_rbar_hit_n,
    // wishbone master
    output logic                         wb_cyc,
    output logic                         wb_stb,
    output logic                         wb_we,
    output logic [63:0]                  wb_adr,
    input  logic [63:0]                  wb_dat_r,
    input  logic                         wb_ack,
    // descriptor out
    output logic                         desc_valid,
    output logic [63:0]                  desc_data,
    output logic [$clog2(NUM_RINGS)-1:0] desc_ring,
    input  logic                         desc_ready
);
    import ptr_pkg::*;

    localparam int RB = $clog2(NUM_RINGS);

    logic          wr_valid;        // decoder to registers
    logic [RB-1:0] wr_ring;
    reg_kind_t     wr_kind;
    logic [63:0]   wr_data;
    logic          req_valid;       // registers to fetcher
    logic [RB-1:0] req_ring;
    logic [63:0]   req_adr;
    logic          req_take;

    tlp_wr_decoder #(.BAR_HIT(BAR_HIT), .NUM_RINGS(NUM_RINGS)) u_decoder (
        .clk, .rst,
        .trn_rd, .trn_rsof_n, .trn_reof_n, .trn_rsrc_rdy_n, .trn_rbar_hit_n,
        .wr_valid, .wr_ring, .wr_kind, .wr_data
    );

    ring_ptr_regs #(.NUM_RINGS(NUM_RINGS), .RING_LOG2(RING_LOG2)) u_regs (
        .clk, .rst,
        .wr_valid, .wr_ring, .wr_kind, .wr_data,
        .req_take, .req_valid, .req_ring, .req_adr
    );

    wb_desc_fetch #(.NUM_RINGS(NUM_RINGS)) u_fetch (
        .clk, .rst,
        .req_valid, .req_ring, .req_adr, .req_take,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_r, .wb_ack,
        .desc_valid, .desc_data, .desc_ring, .desc_ready
    );

endmodule

/* tb_ptr_fetch_assert.sv */
////////////////////////////////////////////////////////////
// protocol and reset checks bound into ptr_fetch_top
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_ptr_fetch_assert #(
    parameter int NUM_RINGS = 4
) (
    input logic                         clk,
    input logic                         rst,
    input logic                         wb_cyc,
    input logic                         wb_stb,
    input logic                         wb_we,
    input logic [63:0]                  wb_adr,
    input logic [63:0]                  wb_dat_r,
    input logic                         wb_ack,
    input logic                         desc_valid,
    input logic [63:0]                  desc_data,
    input logic [$clog2(NUM_RINGS)-1:0] desc_ring,
    input logic                         desc_ready,
    input logic [NUM_RINGS-1:0]         base_ok,
    input ptr_pkg::fetch_state_t        fetch_state
);
    import ptr_pkg::*;

    int fail_cnt = 0;           // failed assertions so far

    // bus and outputs quiet right after reset
    a_reset: assert property (@(posedge clk) rst |=> !wb_cyc && !desc_valid)
        else begin
            $error("bus or descriptor active after reset");
            fail_cnt++;
        end

    // no base written yet so nothing to fetch
    a_no_base: assert property (@(posedge clk) disable iff (rst)
        (base_ok == '0) |-> !wb_cyc && !desc_valid)
        else begin
            $error("fetch before any base was written");
            fail_cnt++;
        end

    a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
        (wb_stb == wb_cyc) && !wb_we)
        else begin
            $error("stb differs from cyc or we is high");
            fail_cnt++;
        end

    a_adr_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && !wb_ack) |=> wb_cyc && $stable(wb_adr))
        else begin
            $error("cyc dropped or adr moved before ack");
            fail_cnt++;
        end

    a_desc_hold: assert property (@(posedge clk) disable iff (rst)
        (desc_valid && !desc_ready) |=>
            desc_valid && $stable(desc_data) && $stable(desc_ring))
        else begin
            $error("descriptor changed while not ready");
            fail_cnt++;
        end

    a_one_item: assert property (@(posedge clk) disable iff (rst) desc_valid |-> !wb_cyc)
        else begin
            $error("bus cycle while descriptor held");
            fail_cnt++;
        end

    // acked read data shows up on the descriptor port one cycle later
    a_ack_data: assert property (@(posedge clk) disable iff (rst)
        (fetch_state == BUS && wb_ack) |=> desc_valid && desc_data == $past(wb_dat_r))
        else begin
            $error("descriptor not presented with the acked data");
            fail_cnt++;
        end

endmodule

bind ptr_fetch_top tb_ptr_fetch_assert #(.NUM_RINGS(NUM_RINGS)) u_chk (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_r, .wb_ack,
    .desc_valid, .desc_data, .desc_ring, .desc_ready,
    .base_ok(u_regs.base_ok_q),
    .fetch_state(u_fetch.state_q)
);

/* tb_ptr_fetch.sv */
////////////////////////////////////////////////////////////
// testbench for ptr_fetch_top with 4 rings of 16 slots on BAR 2
// wishbone memory returns address xor a fixed pattern
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_ptr_fetch;
    import ptr_pkg::*;

    localparam int          BAR_HIT   = 2;
    localparam int          NUM_RINGS = 4;
    localparam int          RING_LOG2 = 4;
    localparam int          SLOTS     = 1 << RING_LOG2;
    localparam logic [63:0] PATTERN   = 64'hA5C3_0F96_5A3C_F069;
    localparam int          DRAIN_MAX = 3000;               // cycles per drain wait

    logic        clk;
    logic        rst;
    logic [63:0] trn_rd;
    logic        trn_rsof_n;
    logic        trn_reof_n;
    logic        trn_rsrc_rdy_n;
    logic [6:0]  trn_rbar_hit_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [63:0] wb_adr;
    logic [63:0] wb_dat_r;
    logic        wb_ack;
    logic        desc_valid;
    logic [63:0] desc_data;
    logic [1:0]  desc_ring;
    logic        desc_ready;

    // host-side model of the rings
    logic [63:0] m_base [NUM_RINGS];
    bit          m_base_ok [NUM_RINGS];
    int          m_sw [NUM_RINGS];
    int          next_slot [NUM_RINGS];  // slot the next descriptor must come from
    int          owed [NUM_RINGS];       // slots still to be fetched
    int          skips [NUM_RINGS];      // descriptors given to other rings meanwhile
    logic [63:0] last_adr;
    logic [31:0] lcg_state = 32'd49971;
    int          ack_wait;
    int          acks;
    int          errors;
    int          timeouts;

    ptr_fetch_top #(.BAR_HIT(BAR_HIT), .NUM_RINGS(NUM_RINGS), .RING_LOG2(RING_LOG2)) u_dut (
        .clk, .rst,
        .trn_rd, .trn_rsof_n, .trn_reof_n, .trn_rsrc_rdy_n, .trn_rbar_hit_n,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_r, .wb_ack,
        .desc_valid, .desc_data, .desc_ring, .desc_ready
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                             // 100 ns period
    end

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};
    endfunction

    function automatic logic [31:0] swap32(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};      // host to wire order
    endfunction

    ////////////////////////////////////////////////////////////
    // wishbone slave and descriptor sink driven on the falling edge
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst) begin
            wb_ack   = 1'b0;
            ack_wait = -1;
        end else if (wb_ack) begin
            wb_ack   = 1'b0;                                // taken on last rising edge
            ack_wait = -1;
        end else if (wb_cyc) begin
            if (ack_wait < 0) begin
                ack_wait = int'(rand_next() % 4);           // 0..3 wait cycles
            end
            if (ack_wait == 0) begin
                wb_ack   = 1'b1;
                wb_dat_r = wb_adr ^ PATTERN;
            end else begin
                ack_wait--;
            end
        end
        desc_ready = (rand_next() % 4) != 0;                // ready 3 of 4 cycles
    end

    // scoreboard samples on the rising edge before outputs move
    always @(posedge clk) begin
        if (!rst && wb_cyc && wb_ack) begin
            last_adr = wb_adr;
            acks++;
        end
        if (!rst && desc_valid && desc_ready) begin
            check_desc(int'(desc_ring), desc_data);
        end
    end

    task automatic check_desc(input int r, input logic [63:0] data);
        logic [63:0] exp_adr;
        if (!m_base_ok[r]) begin
            $display("Error at %0t: descriptor from ring %0d before its base was written",
                     $time, r);
            errors++;
            return;
        end
        if (owed[r] == 0) begin
            $display("Error at %0t: descriptor from ring %0d with no slot owed", $time, r);
            errors++;
            return;
        end
        exp_adr = m_base[r] + 64'(next_slot[r]) * DESC_BYTES;
        if (last_adr !== exp_adr) begin
            $display("Error at %0t: ring %0d read adr %h, expected %h",
                     $time, r, last_adr, exp_adr);
            errors++;
        end
        if (data !== (exp_adr ^ PATTERN)) begin
            $display("Error at %0t: ring %0d desc_data %h, expected %h",
                     $time, r, data, exp_adr ^ PATTERN);
            errors++;
        end
        next_slot[r] = (next_slot[r] + 1) % SLOTS;
        owed[r]--;
        skips[r] = 0;
        for (int i = 0; i < NUM_RINGS; i++) begin
            if (i != r && owed[i] > 0 && m_base_ok[i]) begin
                skips[i]++;
                if (skips[i] > NUM_RINGS) begin
                    $display("Error at %0t: ring %0d starved for %0d descriptors",
                             $time, i, skips[i]);
                    errors++;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // TRN stimulus
    ////////////////////////////////////////////////////////////
    task automatic send_beat(input logic [63:0] d, input bit sof, input bit eof,
                             input logic [6:0] bar_n);
        @(negedge clk);
        trn_rd         = d;
        trn_rsof_n     = !sof;
        trn_reof_n     = !eof;
        trn_rsrc_rdy_n = 1'b0;
        trn_rbar_hit_n = bar_n;
    endtask

    // sends one TLP with the value byte swapped from host order
    task automatic send_tlp(input tlp_fmt_t fmt, input int len, input logic [6:0] bar_n,
                            input logic [31:0] offset, input logic [63:0] value);
        logic [31:0] dw0;
        logic [31:0] addr;
        dw0  = {1'b0, fmt, 14'd0, 10'(len)};
        addr = 32'hF000_0000 | offset;
        send_beat({dw0, 32'h0000_00FF}, 1'b1, 1'b0, bar_n);     // requester, tag, BEs
        case (fmt)
            MWR32: begin
                send_beat({addr, swap32(value[31:0])}, 1'b0, 1'b0, bar_n);
                send_beat({swap32(value[63:32]), 32'd0}, 1'b0, 1'b1, bar_n);
            end
            MWR64: begin
                send_beat({32'h0000_0001, addr}, 1'b0, 1'b0, bar_n);
                send_beat({swap32(value[31:0]), swap32(value[63:32])}, 1'b0, 1'b1, bar_n);
            end
            default: send_beat({addr, 32'd0}, 1'b0, 1'b1, bar_n); // reads carry no data
        endcase
        @(negedge clk);
        trn_rsrc_rdy_n = 1'b1;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
    endtask

    function automatic logic [6:0] bar_sel();
        return ~(7'd1 << BAR_HIT);
    endfunction

    task automatic write_base(input int r, input logic [63:0] base, input tlp_fmt_t fmt);
        send_tlp(fmt, PAYLOAD_DW, bar_sel(), 32'(r * 16), base);
        m_base[r]    = base;
        m_base_ok[r] = 1'b1;
    endtask

    task automatic write_ptr(input int r, input int ptr, input tlp_fmt_t fmt);
        send_tlp(fmt, PAYLOAD_DW, bar_sel(), 32'(r * 16 + 8), 64'(ptr));
        owed[r] += (ptr - m_sw[r]) & (SLOTS - 1);
        m_sw[r]  = ptr;
    endtask

    // waits until every owed slot has come out or gives up
    task automatic wait_drain(output bit ok);
        int n;
        for (n = 0; n < DRAIN_MAX; n++) begin
            @(negedge clk);
            if (!desc_valid && !wb_cyc && owed.sum() == 0) begin
                break;
            end
        end
        ok = (n < DRAIN_MAX);
        if (!ok) begin
            $display("Timeout: descriptors still owed after %0d cycles", DRAIN_MAX);
            timeouts++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic run_tests();
        bit ok;
        write_base(0, 64'h0000_0001_2000_0000, MWR64);
        // each of these must be dropped by the decoder
        send_tlp(MWR64, PAYLOAD_DW, ~7'd1, 32'h08, 64'd3);     // wrong BAR
        send_tlp(MRD32, PAYLOAD_DW, bar_sel(), 32'h08, 64'd0);  // read request
        send_tlp(MWR64, 1, bar_sel(), 32'h08, 64'd3);           // length 1
        send_tlp(MWR32, PAYLOAD_DW, bar_sel(), 32'h108, 64'd3); // outside window
        idle_cycles(20);
        if (acks != 0) begin
            $display("Error at %0t: %0d reads after ignored writes", $time, acks);
            errors++;
        end
        // writes spread over all rings with ring 3 pointer before its base
        write_ptr(3, 4, MWR32);
        write_base(1, 64'h0000_0000_8000_1000, MWR32);
        write_base(2, 64'hFFFF_0000_0040_0000, MWR64);
        write_ptr(0, 3, MWR32);
        write_ptr(1, 5, MWR64);
        write_ptr(2, 2, MWR32);
        write_base(3, 64'h0000_00AB_CDEF_0000, MWR32);
        wait_drain(ok);
        if (!ok) return;
        // wrap ring 2 past the end of its slots
        write_ptr(2, 14, MWR64);
        wait_drain(ok);
        if (!ok) return;
        write_ptr(2, 4, MWR32);
        write_ptr(0, 1, MWR64);
        wait_drain(ok);
        if (!ok) return;
        idle_cycles(10);
        if (acks != 3 + 5 + 2 + 4 + 12 + 6 + 14) begin
            $display("Error at %0t: %0d reads in total, expected 46", $time, acks);
            errors++;
        end
    endtask

    task automatic report_counts();
        $display("errors %0d, assertion failures %0d, timeouts %0d, reads %0d",
                 errors, u_dut.u_chk.fail_cnt, timeouts, acks);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        rst            = 1'b1;
        trn_rd         = '0;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        trn_rbar_hit_n = 7'h7F;
        wb_dat_r       = '0;
        wb_ack         = 1'b0;
        desc_ready     = 1'b0;
        acks           = 0;
        errors         = 0;
        timeouts       = 0;
        last_adr       = '0;
        for (int r = 0; r < NUM_RINGS; r++) begin
            m_base[r]    = '0;
            m_base_ok[r] = 1'b0;
            m_sw[r]      = 0;
            next_slot[r] = 0;
            owed[r]      = 0;
            skips[r]     = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idle_cycles(10);                                    // nothing may start yet
        run_tests();
        report_counts();
        if (errors == 0 && timeouts == 0 && u_dut.u_chk.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* build.f */
ptr_pkg.sv
tlp_wr_decoder.sv
ring_ptr_regs.sv
wb_desc_fetch.sv
ptr_fetch_top.sv
tb_ptr_fetch_assert.sv
tb_ptr_fetch.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the ptr_fetch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_ptr_fetch -o sim_ptr_fetch > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/sim_ptr_fetch +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation passed"
exit 0
